/* build.f */
rtl/amiv_pkg.sv
rtl/amiv_cfg_regs.sv
rtl/amiv_capture.sv
rtl/amiv_interlace_detect.sv
rtl/amiv_out_timing.sv
rtl/amiv_sram_sched.sv
rtl/amiv_top.sv
sim/amiv_tb_sram.sv
sim/amiv_tb.sv

/* rtl/amiv_capture.sv */
`timescale 1ns/100ps

module amiv_capture #(
	parameter int SRAM_WIDTH  = 640,
	parameter int SRAM_HEIGHT = 580
) (
	input  logic                 in_hs,
	input  logic                 reset,
	input  logic                 vid_pclk_en,
	input  logic                 vid_hs,
	input  logic                 vid_vs,
	input  logic                 vid_field,
	input  amiv_pkg::vid_in_t    vid_data,
	input  amiv_pkg::h_blank_t   h_blank,
	input  amiv_pkg::v_blank_t   v_blank,
	input  logic                 interlaced,
	output logic                 wr_req,
	output amiv_pkg::sram_addr_t wr_addr,
	output amiv_pkg::rgb565_t    wr_data,
	input  logic                 wr_ack
);
	import amiv_pkg::*;

	in_pix_t    pix_cnt;
	v_count_t   line_cnt;
	logic       hs_q;
	logic       hs_rise;
	logic       h_in;
	logic       v_in;
	logic       pix_hit;
	sram_addr_t col;
	sram_addr_t row;
	sram_addr_t addr_next;

	assign hs_rise = vid_hs && !hs_q;

	// Pixel count along the line.
	always_ff @(posedge in_hs) begin
		if (reset || !vid_hs) begin
			pix_cnt <= '0;
		end else if (vid_pclk_en) begin
			pix_cnt <= pix_cnt + 1'b1;
		end
	end

	// Line count within the field, cleared during vsync.
	always_ff @(posedge in_hs) begin
		if (reset) begin
			hs_q     <= 1'b0;
			line_cnt <= '0;
		end else begin
			hs_q <= vid_hs;
			if (!vid_vs) begin
				line_cnt <= '0;
			end else if (hs_rise) begin
				line_cnt <= line_cnt + 1'b1;
			end
		end
	end

	// Capture window test.
	assign h_in = int'(pix_cnt) >= int'(h_blank) &&
		int'(pix_cnt) < int'(h_blank) + SRAM_WIDTH;
	assign v_in = int'(line_cnt) >= int'(v_blank) &&
		int'(line_cnt) < int'(v_blank) + SRAM_HEIGHT / 2;
	assign pix_hit = vid_pclk_en && vid_hs && h_in && v_in;

	// Position inside the window.
	assign col = sram_addr_t'(pix_cnt - in_pix_t'(h_blank));
	assign row = sram_addr_t'(line_cnt - v_count_t'(v_blank));

	// Interlaced fields go to alternate rows.
	always_comb begin
		if (interlaced) begin
			addr_next = row * sram_addr_t'(2 * SRAM_WIDTH) + col;
			if (vid_field) begin
				addr_next = addr_next + sram_addr_t'(SRAM_WIDTH);
			end
		end else begin
			addr_next = row * sram_addr_t'(SRAM_WIDTH) + col;
		end
	end

	// Request stays up until the slot sequencer takes it.
	always_ff @(posedge in_hs) begin
		if (reset) begin
			wr_req <= 1'b0;
		end else if (pix_hit) begin
			wr_req <= 1'b1;
		end else if (wr_ack) begin
			wr_req <= 1'b0;
		end
	end

	// Address and packed pixel, top bits of each channel.
	always_ff @(posedge in_hs) begin
		if (pix_hit) begin
			wr_addr <= addr_next;
			wr_data <= {vid_data.r[9:5], vid_data.g[9:4], vid_data.b[9:5]};
		end
	end

	// A new pixel must not land on a pending write.
	assert property (@(posedge in_hs) disable iff (reset)
		pix_hit |-> !wr_req || wr_ack)
		else $error("capture overrun, pixel arrived with a write pending");

endmodule

/* rtl/amiv_cfg_regs.sv */
`timescale 1ns/100ps

module amiv_cfg_regs (
	input  logic                in_hs,
	input  logic                reset,
	input  logic [3:0]          paddr,
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  logic [31:0]         pwdata,
	output logic [31:0]         prdata,
	output logic                pready,
	output logic                pslverr,
	input  logic                interlaced,
	output logic                out_en,
	output amiv_pkg::h_blank_t  h_blank,
	output amiv_pkg::v_blank_t  v_blank
);
	import amiv_pkg::*;

	logic access;
	logic mapped;

	// Access phase of a transfer.
	assign access = psel && penable;

	// Only the four word offsets decode.
	assign mapped = (paddr == REG_CTRL) || (paddr == REG_H_BLANK) ||
		(paddr == REG_V_BLANK) || (paddr == REG_STATUS);

	// No wait states.
	assign pready = access;

	// Status word is read only.
	assign pslverr = access && (!mapped || (pwrite && paddr == REG_STATUS));

	// Read mux.
	always_comb begin
		case (paddr)
			REG_CTRL:    prdata = 32'(out_en);
			REG_H_BLANK: prdata = 32'(h_blank);
			REG_V_BLANK: prdata = 32'(v_blank);
			REG_STATUS:  prdata = 32'(interlaced);
			default:     prdata = '0;
		endcase
	end

	// Writes land at the end of the access cycle.
	always_ff @(posedge in_hs) begin
		if (reset) begin
			out_en  <= 1'b0;
			h_blank <= H_BLANK_DEFAULT;
			v_blank <= V_BLANK_DEFAULT;
		end else if (access && pwrite) begin
			case (paddr)
				REG_CTRL:    out_en  <= pwdata[0];
				REG_H_BLANK: h_blank <= pwdata[8:0];
				REG_V_BLANK: v_blank <= pwdata[7:0];
				default:     ;
			endcase
		end
	end

	// Access phase must be entered from a setup cycle.
	assert property (@(posedge in_hs) disable iff (reset)
		$rose(penable) |-> $past(psel && !penable))
		else $error("penable rose without a setup cycle");

endmodule

/* rtl/amiv_interlace_detect.sv */
`timescale 1ns/100ps

module amiv_interlace_detect #(
	parameter int FRAMES_PER_DETECT = 50
) (
	input  logic in_hs,
	input  logic reset,
	input  logic vid_vs,
	input  logic vid_field,
	output logic interlaced
);
	localparam int CNT_W = $clog2(FRAMES_PER_DETECT + 1);
	localparam logic [CNT_W-1:0] LAST_FRAME = CNT_W'(FRAMES_PER_DETECT - 1);

	logic             vs_q;
	logic             vs_rise;
	logic             field_low_seen;
	logic [CNT_W-1:0] frame_cnt;

	// One edge per frame.
	assign vs_rise = vid_vs && !vs_q;

	always_ff @(posedge in_hs) begin
		if (reset) begin
			vs_q           <= 1'b0;
			frame_cnt      <= '0;
			field_low_seen <= 1'b0;
			interlaced     <= 1'b0;
		end else begin
			vs_q <= vid_vs;
			if (vs_rise) begin
				if (frame_cnt == LAST_FRAME) begin
					// Window closes, publish and start over.
					interlaced     <= field_low_seen || !vid_field;
					field_low_seen <= 1'b0;
					frame_cnt      <= '0;
				end else begin
					frame_cnt <= frame_cnt + 1'b1;
					if (!vid_field) begin
						field_low_seen <= 1'b1;
					end
				end
			end
		end
	end

endmodule

/* rtl/amiv_out_timing.sv */
`timescale 1ns/100ps

module amiv_out_timing #(
	parameter int SRAM_WIDTH        = 640,
	parameter int SRAM_HEIGHT       = 580,
	parameter int OUT_HFP           = 440,
	parameter int OUT_HSW           = 40,
	parameter int OUT_HBP           = 220,
	parameter int OUT_WIDTH         = 1280,
	parameter int OUT_VFP           = 5,
	parameter int OUT_VSW           = 5,
	parameter int OUT_VBP           = 20,
	parameter int OUT_HEIGHT        = 720,
	parameter int OUT_HEIGHT_OFFSET = 78
) (
	input  logic                 in_hs,
	input  logic                 reset,
	input  logic                 out_en,
	input  logic                 pix_tick,
	input  logic                 interlaced,
	output logic                 hdmi_hs,
	output logic                 hdmi_vs,
	output logic                 in_window,
	output amiv_pkg::sram_addr_t rd_addr
);
	import amiv_pkg::*;

	localparam int H_BLANK = OUT_HFP + OUT_HSW + OUT_HBP;
	localparam int H_TOTAL = OUT_WIDTH + H_BLANK;
	localparam int V_BLANK = OUT_VFP + OUT_VSW + OUT_VBP;
	localparam int V_TOTAL = OUT_HEIGHT + V_BLANK;
	localparam int V_WIN   = V_BLANK + OUT_HEIGHT_OFFSET;

	h_count_t   h_cnt;
	v_count_t   v_cnt;
	logic       h_win;
	logic       v_win;
	h_count_t   h_rel;
	v_count_t   v_rel;
	sram_addr_t col;
	sram_addr_t row;

	// Raster counters, parked at zero while disabled.
	always_ff @(posedge in_hs) begin
		if (reset || !out_en) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (pix_tick) begin
			if (h_cnt == h_count_t'(H_TOTAL - 1)) begin
				h_cnt <= '0;
				if (v_cnt == v_count_t'(V_TOTAL - 1)) begin
					v_cnt <= '0;
				end else begin
					v_cnt <= v_cnt + 1'b1;
				end
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	// Syncs, one clock behind the counters.
	always_ff @(posedge in_hs) begin
		if (reset || !out_en) begin
			hdmi_hs <= 1'b0;
			hdmi_vs <= 1'b0;
		end else begin
			hdmi_hs <= h_cnt >= h_count_t'(OUT_HFP) &&
				h_cnt < h_count_t'(OUT_HFP + OUT_HSW);
			hdmi_vs <= v_cnt >= v_count_t'(OUT_VBP) &&
				v_cnt < v_count_t'(OUT_VBP + OUT_VSW);
		end
	end

	// Picture area.
	// Twice the stored width, full stored height.
	assign h_win = h_cnt >= h_count_t'(H_BLANK) &&
		h_cnt < h_count_t'(H_BLANK + 2 * SRAM_WIDTH);
	assign v_win = v_cnt >= v_count_t'(V_WIN) &&
		v_cnt < v_count_t'(V_WIN + SRAM_HEIGHT);
	assign in_window = h_win && v_win;

	// Each stored pixel covers two output pixels.
	assign h_rel = h_cnt - h_count_t'(H_BLANK);
	assign v_rel = v_cnt - v_count_t'(V_WIN);
	assign col   = sram_addr_t'(h_rel >> 1);

	// Progressive lines repeat, interlaced rows map one to one.
	assign row = interlaced ? sram_addr_t'(v_rel) : sram_addr_t'(v_rel >> 1);

	assign rd_addr = in_window ? row * sram_addr_t'(SRAM_WIDTH) + col : '0;

endmodule

/* rtl/amiv_pkg.sv */
package amiv_pkg;

	// Raw input pixel from the ADC.
	// Three 10-bit channels, red in the top bits.
	typedef struct packed {
		logic [9:0] r;
		logic [9:0] g;
		logic [9:0] b;
	} vid_in_t;

	// Stored pixel, 5 red, 6 green, 5 blue.
	typedef logic [15:0] rgb565_t;

	// Output pixel to the HDMI transmitter.
	typedef logic [23:0] rgb888_t;

	// SRAM word address.
	typedef logic [18:0] sram_addr_t;

	// Output pixel counter.
	typedef logic [11:0] h_count_t;

	// Line counter, input and output side.
	typedef logic [9:0] v_count_t;

	// Input pixel counter.
	typedef logic [9:0] in_pix_t;

	// Capture offsets.
	typedef logic [8:0] h_blank_t;
	typedef logic [7:0] v_blank_t;

	// Phases of the shared SRAM slot.
	typedef enum logic [1:0] {
		PH_READ_ADDR = 2'd0,
		PH_READ_DATA = 2'd1,
		PH_WRITE     = 2'd2,
		PH_IDLE      = 2'd3
	} slot_phase_t;

	// APB byte offsets, one 32-bit word each.
	localparam logic [3:0] REG_CTRL    = 4'h0;
	localparam logic [3:0] REG_H_BLANK = 4'h4;
	localparam logic [3:0] REG_V_BLANK = 4'h8;
	localparam logic [3:0] REG_STATUS  = 4'hC;

	// Offsets loaded at reset.
	localparam h_blank_t H_BLANK_DEFAULT = 9'd170;
	localparam v_blank_t V_BLANK_DEFAULT = 8'd30;

endpackage

/* rtl/amiv_sram_sched.sv */
`timescale 1ns/100ps

module amiv_sram_sched (
	input  logic                 in_hs,
	input  logic                 reset,
	input  logic                 out_en,
	input  amiv_pkg::sram_addr_t rd_addr,
	input  logic                 in_window,
	input  logic                 wr_req,
	input  amiv_pkg::sram_addr_t wr_addr,
	input  amiv_pkg::rgb565_t    wr_data,
	output logic                 wr_ack,
	output logic                 pix_tick,
	output logic                 hdmi_pclk,
	output amiv_pkg::rgb888_t    hdmi_data,
	output amiv_pkg::sram_addr_t sram_addr,
	output logic                 sram_we_n,
	inout  wire [15:0]           sram_data
);
	import amiv_pkg::*;

	slot_phase_t phase;
	logic        wr_go;
	logic        win_q;
	rgb565_t     wdata_q;
	rgb888_t     rd_pix;

	// Slot phase, held at the first phase while disabled.
	always_ff @(posedge in_hs) begin
		if (reset || !out_en) begin
			phase <= PH_READ_ADDR;
		end else begin
			phase <= slot_phase_t'(phase + 2'd1);
		end
	end

	// Two output pixels per slot.
	assign pix_tick  = out_en && (phase == PH_READ_ADDR || phase == PH_WRITE);
	assign hdmi_pclk = (phase == PH_READ_DATA) || (phase == PH_IDLE);

	// Pending write is booked for the next phase.
	assign wr_go = out_en && phase == PH_READ_DATA && wr_req;

	// Low bits of each channel zero filled.
	assign rd_pix = {sram_data[15:11], 3'b000, sram_data[10:5], 2'b00,
		sram_data[4:0], 3'b000};

	// Bus only driven in the write phase.
	assign sram_data = sram_we_n ? 16'bz : wdata_q;

	// Read address from the idle phase, write address for the write phase.
	always_ff @(posedge in_hs) begin
		if (reset) begin
			sram_addr <= '0;
		end else if (wr_go) begin
			sram_addr <= wr_addr;
		end else if (out_en && phase == PH_IDLE) begin
			sram_addr <= rd_addr;
		end
	end

	always_ff @(posedge in_hs) begin
		if (wr_go) begin
			wdata_q <= wr_data;
		end
	end

	// Strobe and ack cover the whole write phase.
	// Read data is captured at the end of PH_READ_DATA.
	always_ff @(posedge in_hs) begin
		if (reset) begin
			sram_we_n <= 1'b1;
			wr_ack    <= 1'b0;
			win_q     <= 1'b0;
			hdmi_data <= '0;
		end else begin
			sram_we_n <= !wr_go;
			wr_ack    <= wr_go;
			if (!out_en) begin
				win_q     <= 1'b0;
				hdmi_data <= '0;
			end else if (phase == PH_IDLE) begin
				win_q <= in_window;
			end else if (phase == PH_READ_DATA) begin
				hdmi_data <= win_q ? rd_pix : '0;
			end
		end
	end

	// Write strobe confined to its phase.
	assert property (@(posedge in_hs) disable iff (reset)
		!sram_we_n |-> phase == PH_WRITE)
		else $error("sram_we_n low outside PH_WRITE");

	// Acked word and address are still the ones capture holds.
	assert property (@(posedge in_hs) disable iff (reset)
		wr_ack |-> wr_req && sram_addr == wr_addr && sram_data == wr_data)
		else $error("write ack without a matching held request");

endmodule

/* rtl/amiv_top.sv */
`timescale 1ns/100ps

module amiv_top #(
	parameter int SRAM_WIDTH        = 640,
	parameter int SRAM_HEIGHT       = 580,
	parameter int OUT_HFP           = 440,
	parameter int OUT_HSW           = 40,
	parameter int OUT_HBP           = 220,
	parameter int OUT_WIDTH         = 1280,
	parameter int OUT_VFP           = 5,
	parameter int OUT_VSW           = 5,
	parameter int OUT_VBP           = 20,
	parameter int OUT_HEIGHT        = 720,
	parameter int OUT_HEIGHT_OFFSET = 78,
	parameter int FRAMES_PER_DETECT = 50
) (
	input  logic                 in_hs,
	input  logic                 reset,
	input  logic                 vid_pclk_en,
	input  logic                 vid_hs,
	input  logic                 vid_vs,
	input  logic                 vid_field,
	input  amiv_pkg::vid_in_t    vid_data,
	input  logic [3:0]           paddr,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  logic [31:0]          pwdata,
	output logic [31:0]          prdata,
	output logic                 pready,
	output logic                 pslverr,
	output logic                 hdmi_pclk,
	output logic                 hdmi_hs,
	output logic                 hdmi_vs,
	output amiv_pkg::rgb888_t    hdmi_data,
	output amiv_pkg::sram_addr_t sram_addr,
	output logic                 sram_we_n,
	inout  wire [15:0]           sram_data
);
	import amiv_pkg::*;

	logic       out_en;
	h_blank_t   h_blank;
	v_blank_t   v_blank;
	logic       interlaced;
	logic       wr_req;
	sram_addr_t wr_addr;
	rgb565_t    wr_data;
	logic       wr_ack;
	logic       pix_tick;
	logic       in_window;
	sram_addr_t rd_addr;

	// APB configuration.
	amiv_cfg_regs cfg_i (
		.in_hs(in_hs), .reset(reset),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.interlaced(interlaced), .out_en(out_en),
		.h_blank(h_blank), .v_blank(v_blank)
	);

	// Input side.
	amiv_capture #(.SRAM_WIDTH(SRAM_WIDTH), .SRAM_HEIGHT(SRAM_HEIGHT)) capture_i (
		.in_hs(in_hs), .reset(reset),
		.vid_pclk_en(vid_pclk_en), .vid_hs(vid_hs), .vid_vs(vid_vs),
		.vid_field(vid_field), .vid_data(vid_data),
		.h_blank(h_blank), .v_blank(v_blank), .interlaced(interlaced),
		.wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_ack(wr_ack)
	);

	amiv_interlace_detect #(.FRAMES_PER_DETECT(FRAMES_PER_DETECT)) detect_i (
		.in_hs(in_hs), .reset(reset),
		.vid_vs(vid_vs), .vid_field(vid_field), .interlaced(interlaced)
	);

	// Output raster.
	amiv_out_timing #(
		.SRAM_WIDTH(SRAM_WIDTH), .SRAM_HEIGHT(SRAM_HEIGHT),
		.OUT_HFP(OUT_HFP), .OUT_HSW(OUT_HSW), .OUT_HBP(OUT_HBP), .OUT_WIDTH(OUT_WIDTH),
		.OUT_VFP(OUT_VFP), .OUT_VSW(OUT_VSW), .OUT_VBP(OUT_VBP), .OUT_HEIGHT(OUT_HEIGHT),
		.OUT_HEIGHT_OFFSET(OUT_HEIGHT_OFFSET)
	) timing_i (
		.in_hs(in_hs), .reset(reset),
		.out_en(out_en), .pix_tick(pix_tick), .interlaced(interlaced),
		.hdmi_hs(hdmi_hs), .hdmi_vs(hdmi_vs),
		.in_window(in_window), .rd_addr(rd_addr)
	);

	// Shared SRAM slot.
	amiv_sram_sched sched_i (
		.in_hs(in_hs), .reset(reset), .out_en(out_en),
		.rd_addr(rd_addr), .in_window(in_window),
		.wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_ack(wr_ack),
		.pix_tick(pix_tick), .hdmi_pclk(hdmi_pclk), .hdmi_data(hdmi_data),
		.sram_addr(sram_addr), .sram_we_n(sram_we_n), .sram_data(sram_data)
	);

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module amiv_tb -o amiv_sim
./obj_dir/amiv_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Finished with errors" sim.log; then
	exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
	exit 1
fi
exit 0

/* sim/amiv_tb.sv */
`timescale 1ns/100ps

module amiv_tb;
	import amiv_pkg::*;

	localparam int SW = 8;
	localparam int SH = 8;
	localparam int H_TOT = 24;
	localparam int V_TOT = 20;
	localparam int H_WIN = 8;
	localparam int V_WIN = 6;
	localparam int NFR = 8;
	localparam int TMO = 4000;
	localparam int SEED = 32'h96b7;

	logic in_hs, reset, vid_pclk_en, vid_hs, vid_vs, vid_field;
	logic [29:0] vid_data;
	logic [3:0] paddr;
	logic psel, penable, pwrite, pready, pslverr;
	logic [31:0] pwdata, prdata;
	logic hdmi_pclk, hdmi_hs, hdmi_vs, sram_we_n;
	rgb888_t hdmi_data;
	sram_addr_t sram_addr;
	wire [15:0] sram_data;
	integer seed;
	rgb565_t exp_mem [64];
	bit written [64];

	// Frames: field, offsets, seed offset, expected interlace, display check.
	int tbl_field [NFR] = '{1, 0, 1, 0, 1, 1, 1, 1};
	int tbl_hb [NFR] = '{2, 3, 2, 2, 3, 2, 2, 2};
	int tbl_vb [NFR] = '{1, 2, 1, 1, 2, 1, 1, 1};
	int tbl_seed [NFR] = '{0, 1, 2, 3, 4, 5, 6, 7};
	int tbl_il [NFR] = '{0, 0, 0, 1, 1, 1, 1, 0};
	int tbl_disp [NFR] = '{1, 0, 0, 0, 1, 0, 0, 0};

	amiv_top #(
		.SRAM_WIDTH(SW), .SRAM_HEIGHT(SH), .OUT_WIDTH(16), .OUT_HFP(3), .OUT_HSW(2),
		.OUT_HBP(3), .OUT_HEIGHT(16), .OUT_VFP(1), .OUT_VSW(1), .OUT_VBP(2),
		.OUT_HEIGHT_OFFSET(2), .FRAMES_PER_DETECT(4)
	) dut_i (.*);

	amiv_tb_sram sram_i (.*);

	always #50 in_hs = ~in_hs;

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else fail_now($sformatf("ERR %s got %h expected %h", name, got, exp));
	endtask

	// One APB transfer, setup then access until pready.
	task automatic apb_xfer(input logic [3:0] a, input logic wr, input logic [31:0] wd,
		output logic [31:0] rd, output logic err);
		int t;
		@(posedge in_hs);
		paddr <= a;
		pwrite <= wr;
		pwdata <= wd;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge in_hs);
		penable <= 1'b1;
		t = 0;
		do begin
			@(negedge in_hs);
			t++;
			if (t > TMO) fail_now("APB transfer never saw pready");
		end while (!pready);
		// No wait states, pready in the first access cycle.
		check_eq("pready delay", 32'(t), 32'd1);
		rd = prdata;
		err = pslverr;
		@(posedge in_hs);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic reg_write(input logic [3:0] a, input logic [31:0] d, input logic exp_err);
		logic [31:0] rd;
		logic err;
		apb_xfer(a, 1'b1, d, rd, err);
		check_eq("pslverr", 32'(err), 32'(exp_err));
	endtask

	task automatic reg_expect(input logic [3:0] a, input logic [31:0] exp, input logic exp_err);
		logic [31:0] rd;
		logic err;
		apb_xfer(a, 1'b0, 32'd0, rd, err);
		check_eq("pslverr", 32'(err), 32'(exp_err));
		if (!exp_err) check_eq("prdata", rd, exp);
	endtask

	// Strobe lands on the write phase, so the request drains within the slot.
	task automatic send_pixel(input int line, input int p, input int f);
		logic [31:0] rnd;
		int a;
		int t;
		t = 0;
		do begin
			@(negedge in_hs);
			t++;
			if (t > TMO) fail_now("SRAM slot never reached the read data phase");
		end while (dut_i.sched_i.phase != PH_READ_DATA);
		rnd = $random(seed);
		@(posedge in_hs);
		vid_pclk_en <= 1'b1;
		vid_data <= rnd[29:0];
		if (line >= tbl_vb[f] && line < tbl_vb[f] + SH / 2 &&
			p >= tbl_hb[f] && p < tbl_hb[f] + SW) begin
			// Expected address from the window position.
			if (tbl_il[f] != 0) begin
				a = (line - tbl_vb[f]) * 2 * SW + p - tbl_hb[f] + tbl_field[f] * SW;
			end else begin
				a = (line - tbl_vb[f]) * SW + p - tbl_hb[f];
			end
			exp_mem[a] = {rnd[29:25], rnd[19:14], rnd[9:5]};
			written[a] = 1'b1;
		end
		@(posedge in_hs);
		vid_pclk_en <= 1'b0;
	endtask

	task automatic send_frame(input int f);
		int t;
		seed = SEED + tbl_seed[f];
		reg_write(REG_H_BLANK, 32'(tbl_hb[f]), 1'b0);
		reg_write(REG_V_BLANK, 32'(tbl_vb[f]), 1'b0);
		reg_expect(REG_H_BLANK, 32'(tbl_hb[f]), 1'b0);
		reg_expect(REG_V_BLANK, 32'(tbl_vb[f]), 1'b0);
		@(posedge in_hs);
		vid_field <= tbl_field[f][0];
		vid_vs <= 1'b0;
		repeat (2) @(posedge in_hs);
		vid_vs <= 1'b1;
		// One line past the window.
		for (int line = 1; line <= tbl_vb[f] + SH / 2; line++) begin
			@(posedge in_hs);
			vid_hs <= 1'b1;
			for (int p = 0; p <= tbl_hb[f] + SW; p++) begin
				send_pixel(line, p, f);
			end
			@(posedge in_hs);
			vid_hs <= 1'b0;
		end
		t = 0;
		while (dut_i.capture_i.wr_req) begin
			@(negedge in_hs);
			t++;
			if (t > TMO) fail_now("capture write request never drained");
		end
		for (int i = 0; i < 64; i++) begin
			if (written[i]) check_eq("sram_data", 32'(sram_i.peek(19'(i))), 32'(exp_mem[i]));
		end
		reg_expect(REG_STATUS, 32'(tbl_il[f]), 1'b0);
	endtask

	// Restart the raster and follow one frame of pixel clocks.
	task automatic check_display(input int il);
		int n, t, m, h, v, a, hs_hi, vs_hi, last_hs, hs_n, vs_n;
		logic pp, ph, pv;
		rgb565_t s;
		rgb888_t e;
		reg_write(REG_CTRL, 32'd0, 1'b0);
		reg_write(REG_CTRL, 32'd1, 1'b0);
		n = 0;
		t = 0;
		hs_hi = 0;
		vs_hi = 0;
		hs_n = 0;
		vs_n = 0;
		last_hs = -1;
		pp = 1'b0;
		ph = 1'b0;
		pv = 1'b0;
		while (n <= H_TOT * V_TOT) begin
			@(negedge in_hs);
			t++;
			if (t > TMO) fail_now("display did not finish a frame of pixel clocks");
			if (hdmi_hs && !ph) begin
				if (last_hs >= 0) check_eq("hdmi_hs period", 32'(n - last_hs), 32'(H_TOT));
				last_hs = n;
				hs_n++;
			end
			if (!hdmi_hs && ph) begin
				check_eq("hdmi_hs width", 32'(hs_hi), 32'd2);
				hs_hi = 0;
			end
			if (!hdmi_vs && pv) begin
				check_eq("hdmi_vs width", 32'(vs_hi), 32'(H_TOT));
				vs_hi = 0;
				vs_n++;
			end
			if (hdmi_pclk && !pp) begin
				if (hdmi_hs) hs_hi++;
				if (hdmi_vs) vs_hi++;
				// Data seen at a rising pclk belongs to the previous raster pixel.
				if (n > 0) begin
					m = n - 1;
					h = m % H_TOT;
					v = (m / H_TOT) % V_TOT;
					e = '0;
					if (h >= H_WIN && h < H_WIN + 2 * SW && v >= V_WIN && v < V_WIN + SH) begin
						a = ((il != 0) ? v - V_WIN : (v - V_WIN) / 2) * SW + (h - H_WIN) / 2;
						s = exp_mem[a];
						e = {s[15:11], 3'b000, s[10:5], 2'b00, s[4:0], 3'b000};
					end
					check_eq("hdmi_data", 32'(hdmi_data), 32'(e));
				end
				n++;
			end
			pp = hdmi_pclk;
			ph = hdmi_hs;
			pv = hdmi_vs;
		end
		// One hsync per line and one vsync per frame.
		check_eq("hdmi_hs pulses", 32'(hs_n), 32'(V_TOT));
		check_eq("hdmi_vs pulses", 32'(vs_n), 32'd1);
	endtask

	initial begin
		in_hs = 1'b0;
		reset = 1'b1;
		{vid_pclk_en, vid_hs, vid_vs, vid_field} = '0;
		vid_data = '0;
		{paddr, psel, penable, pwrite, pwdata} = '0;
		seed = SEED;
		repeat (10) @(posedge in_hs);
		reset <= 1'b0;
		// Quiet outputs while disabled.
		repeat (16) begin
			@(negedge in_hs);
			check_eq("hdmi_pclk", 32'(hdmi_pclk), 32'd0);
			check_eq("hdmi_hs", 32'(hdmi_hs), 32'd0);
			check_eq("hdmi_vs", 32'(hdmi_vs), 32'd0);
			check_eq("hdmi_data", 32'(hdmi_data), 32'd0);
			check_eq("sram_we_n", 32'(sram_we_n), 32'd1);
		end
		for (int i = 0; i < 64; i++) begin
			exp_mem[i] = sram_i.peek(19'(i));
		end
		// Reset offsets.
		reg_expect(REG_H_BLANK, 32'd170, 1'b0);
		reg_expect(REG_V_BLANK, 32'd30, 1'b0);
		reg_expect(4'h2, 32'd0, 1'b1);
		reg_write(REG_STATUS, 32'd1, 1'b1);
		reg_write(REG_CTRL, 32'd1, 1'b0);
		reg_expect(REG_CTRL, 32'd1, 1'b0);
		for (int f = 0; f < NFR; f++) begin
			send_frame(f);
			if (tbl_disp[f] != 0) check_display(tbl_il[f]);
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

/* sim/amiv_tb_sram.sv */
`timescale 1ns/100ps

module amiv_tb_sram (
	input  logic [18:0] sram_addr,
	input  logic        sram_we_n,
	inout  wire  [15:0] sram_data
);
	logic [15:0] mem [0:(1 << 19) - 1];
	logic [18:0] wr_addr_q;
	logic [15:0] wr_data_q;

	// Fill pattern, every address bit matters.
	initial begin
		for (int i = 0; i < (1 << 19); i++) begin
			mem[i] = 16'(i ^ (i >> 5) ^ (i >> 16));
		end
	end

	// Asynchronous read whenever the write strobe is high.
	assign sram_data = sram_we_n ? mem[sram_addr] : 16'bz;

	// Address and data follow the bus during the strobe.
	always_latch begin
		if (!sram_we_n) begin
			wr_addr_q <= sram_addr;
			wr_data_q <= sram_data;
		end
	end

	// Word lands at the end of the strobe.
	always @(posedge sram_we_n) begin
		mem[wr_addr_q] <= wr_data_q;
	end

	// Backdoor for the checks.
	function automatic logic [15:0] peek(input logic [18:0] a);
		return mem[a];
	endfunction

endmodule
